/* Makefile */
TOP := digital_core_tb

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator, run it, check sim.log"
	@echo "  clean  remove obj_dir and sim.log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --timescale 1ns/1ps -f list.f \
		--top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee sim.log
	@if grep -q "RESULT: PASS" sim.log; then \
		echo "simulation passed"; \
	else \
		echo "simulation failed"; \
		exit 1; \
	fi

clean:
	rm -rf obj_dir sim.log

/* list.f */
logic/dcore_pkg.sv
logic/adc_retimer.sv
logic/adc_unfolding.sv
logic/slice_comparator.sv
logic/prbs_checker.sv
logic/dcore_apb_regs.sv
logic/digital_core.sv
tests/digital_core_tb.sv

/* logic/adc_retimer.sv */
`timescale 1ns/1ps

module adc_retimer #(
    parameter int n_ti  = dcore_pkg::n_ti_default,
    parameter int n_adc = dcore_pkg::n_adc_default
) (
    input  logic                        clk_adc_i,
    input  logic                        arst_n_i,
    input  logic [n_ti-1:0][n_adc-1:0]  data_i,
    input  logic [n_ti-1:0]             sign_i,
    input  logic [n_ti-1:0]             delay_mask_i,
    output logic [n_ti-1:0][n_adc-1:0]  data_o,
    output logic [n_ti-1:0]             sign_o
);

    // first capture and one extra cycle of delay
    logic [n_ti-1:0][n_adc-1:0] data_q;
    logic [n_ti-1:0][n_adc-1:0] data_dly_q;
    logic [n_ti-1:0]            sign_q;
    logic [n_ti-1:0]            sign_dly_q;

    always_ff @(posedge clk_adc_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            data_q     <= '0;
            data_dly_q <= '0;
            sign_q     <= '0;
            sign_dly_q <= '0;
        end else begin
            data_q     <= data_i;
            data_dly_q <= data_q;
            sign_q     <= sign_i;
            sign_dly_q <= sign_q;
        end
    end

    // early slices take the delayed copy
    for (genvar k = 0; k < n_ti; k++) begin : g_slice
        assign data_o[k] = delay_mask_i[k] ? data_dly_q[k] : data_q[k];
        assign sign_o[k] = delay_mask_i[k] ? sign_dly_q[k] : sign_q[k];
    end

endmodule

/* logic/adc_unfolding.sv */
`timescale 1ns/1ps

module adc_unfolding #(
    parameter int n_ti  = dcore_pkg::n_ti_default,
    parameter int n_adc = dcore_pkg::n_adc_default
) (
    input  logic                              clk_adc_i,
    input  logic                              arst_n_i,
    input  logic [n_ti-1:0][n_adc-1:0]        data_i,
    input  logic [n_ti-1:0]                   sign_i,
    input  logic signed [n_adc:0]             pfd_offset_i,
    output logic signed [n_ti-1:0][n_adc:0]   value_o
);

    // headroom for magnitude minus a full-range offset
    localparam int wide = n_adc + 3;

    localparam logic signed [wide-1:0] sat_max = (2 ** n_adc) - 1;
    localparam logic signed [wide-1:0] sat_min = -(2 ** n_adc);

    logic signed [wide-1:0]   unfolded [n_ti];
    logic signed [wide-1:0]   diff [n_ti];
    logic [n_ti-1:0][n_adc:0] value_d;

    always_comb begin
        for (int k = 0; k < n_ti; k++) begin
            // sign bit high means a positive code
            unfolded[k] = $signed(wide'(data_i[k]));
            if (!sign_i[k]) begin
                unfolded[k] = -unfolded[k];
            end

            diff[k] = unfolded[k] - wide'(pfd_offset_i);

            // clamp into the signed n_adc+1 range
            if (diff[k] > sat_max) begin
                value_d[k] = sat_max[n_adc:0];
            end else if (diff[k] < sat_min) begin
                value_d[k] = sat_min[n_adc:0];
            end else begin
                value_d[k] = diff[k][n_adc:0];
            end
        end
    end

    always_ff @(posedge clk_adc_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            value_o <= '0;
        end else begin
            value_o <= value_d;
        end
    end

endmodule

/* logic/dcore_apb_regs.sv */
`timescale 1ns/1ps

module dcore_apb_regs #(
    parameter int n_ti  = dcore_pkg::n_ti_default,
    parameter int n_adc = dcore_pkg::n_adc_default
) (
    input  logic                   clk_adc_i,
    input  logic                   arst_n_i,
    input  logic [4:0]             paddr_i,
    input  logic                   psel_i,
    input  logic                   penable_i,
    input  logic                   pwrite_i,
    input  logic [31:0]            pwdata_i,
    output logic [31:0]            prdata_o,
    output logic                   pready_o,
    output logic                   pslverr_o,
    input  logic [31:0]            err_cnt_i,
    input  logic [31:0]            total_cnt_i,
    output logic [n_ti-1:0]        delay_mask_o,
    output logic signed [n_adc:0]  pfd_offset_o,
    output logic signed [n_adc:0]  thresh_o,
    output logic                   prbs_en_o,
    output logic                   prbs_inv_o
);

    import dcore_pkg::*;

    // ctrl layout
    localparam int mask_lsb = 8;

    reg_addr_e addr;
    logic      access;
    logic      addr_ok;
    logic      read_only;
    logic      wr_en;

    assign addr   = reg_addr_e'(paddr_i);
    assign access = psel_i & penable_i;

    // address decode and read mux
    always_comb begin
        addr_ok   = 1'b1;
        read_only = 1'b0;
        prdata_o  = '0;
        case (addr)
            REG_CTRL: begin
                prdata_o[0]               = prbs_en_o;
                prdata_o[1]               = prbs_inv_o;
                prdata_o[mask_lsb +: n_ti] = delay_mask_o;
            end
            REG_OFFSET: begin
                prdata_o[n_adc:0] = pfd_offset_o;
            end
            REG_THRESH: begin
                prdata_o[n_adc:0] = thresh_o;
            end
            REG_ERR_CNT: begin
                prdata_o  = err_cnt_i;
                read_only = 1'b1;
            end
            REG_TOTAL_CNT: begin
                prdata_o  = total_cnt_i;
                read_only = 1'b1;
            end
            default: begin
                addr_ok = 1'b0;
            end
        endcase
    end

    // no wait states
    assign pready_o = 1'b1;

    // bad address, or a write to a counter
    assign pslverr_o = access & (~addr_ok | (pwrite_i & read_only));
    assign wr_en     = access & pwrite_i & addr_ok & ~read_only;

    always_ff @(posedge clk_adc_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            prbs_en_o    <= 1'b0;
            prbs_inv_o   <= 1'b0;
            delay_mask_o <= '0;
            pfd_offset_o <= '0;
            thresh_o     <= '0;
        end else if (wr_en) begin
            case (addr)
                REG_CTRL: begin
                    prbs_en_o    <= pwdata_i[0];
                    prbs_inv_o   <= pwdata_i[1];
                    delay_mask_o <= pwdata_i[mask_lsb +: n_ti];
                end
                REG_OFFSET: begin
                    pfd_offset_o <= $signed(pwdata_i[n_adc:0]);
                end
                REG_THRESH: begin
                    thresh_o <= $signed(pwdata_i[n_adc:0]);
                end
                default: begin
                end
            endcase
        end
    end

endmodule

/* logic/dcore_pkg.sv */
package dcore_pkg;

    // default datapath sizes
    localparam int n_ti_default  = 4;
    localparam int n_adc_default = 7;

    // prbs7, taps at 6 and 7
    localparam int prbs_order = 7;

    // apb word addresses
    typedef enum logic [4:0] {
        REG_CTRL      = 5'h00,
        REG_OFFSET    = 5'h04,
        REG_THRESH    = 5'h08,
        // counters are read only
        REG_ERR_CNT   = 5'h0C,
        REG_TOTAL_CNT = 5'h10
    } reg_addr_e;

    // checker sequencing
    typedef enum logic [1:0] {
        PRBS_IDLE,
        PRBS_SEED,
        PRBS_CHECK
    } prbs_state_e;

endpackage

/* logic/digital_core.sv */
`timescale 1ns/1ps

module digital_core #(
    parameter int n_ti  = dcore_pkg::n_ti_default,
    parameter int n_adc = dcore_pkg::n_adc_default
) (
    input  logic                        clk_adc_i,
    input  logic                        arst_n_i,
    input  logic [4:0]                  paddr_i,
    input  logic                        psel_i,
    input  logic                        penable_i,
    input  logic                        pwrite_i,
    input  logic [31:0]                 pwdata_i,
    output logic [31:0]                 prdata_o,
    output logic                        pready_o,
    output logic                        pslverr_o,
    input  logic [n_ti-1:0][n_adc-1:0]  adcout_i,
    input  logic [n_ti-1:0]             adcout_sign_i
);

    // register file outputs
    logic [n_ti-1:0]        delay_mask;
    logic signed [n_adc:0]  pfd_offset;
    logic signed [n_adc:0]  thresh;
    logic                   prbs_en;
    logic                   prbs_inv;
    logic [31:0]            err_cnt;
    logic [31:0]            total_cnt;

    // pipeline
    logic [n_ti-1:0][n_adc-1:0]       adcout_retimed;
    logic [n_ti-1:0]                  sign_retimed;
    logic signed [n_ti-1:0][n_adc:0]  adcout_unfolded;
    logic [n_ti-1:0]                  rx_bits;

    dcore_apb_regs #(.n_ti(n_ti), .n_adc(n_adc)) regs_i (
        .clk_adc_i   (clk_adc_i),
        .arst_n_i    (arst_n_i),
        .paddr_i     (paddr_i),
        .psel_i      (psel_i),
        .penable_i   (penable_i),
        .pwrite_i    (pwrite_i),
        .pwdata_i    (pwdata_i),
        .prdata_o    (prdata_o),
        .pready_o    (pready_o),
        .pslverr_o   (pslverr_o),
        .err_cnt_i   (err_cnt),
        .total_cnt_i (total_cnt),
        .delay_mask_o(delay_mask),
        .pfd_offset_o(pfd_offset),
        .thresh_o    (thresh),
        .prbs_en_o   (prbs_en),
        .prbs_inv_o  (prbs_inv)
    );

    adc_retimer #(.n_ti(n_ti), .n_adc(n_adc)) retimer_i (
        .clk_adc_i   (clk_adc_i),
        .arst_n_i    (arst_n_i),
        .data_i      (adcout_i),
        .sign_i      (adcout_sign_i),
        .delay_mask_i(delay_mask),
        .data_o      (adcout_retimed),
        .sign_o      (sign_retimed)
    );

    adc_unfolding #(.n_ti(n_ti), .n_adc(n_adc)) unfold_i (
        .clk_adc_i   (clk_adc_i),
        .arst_n_i    (arst_n_i),
        .data_i      (adcout_retimed),
        .sign_i      (sign_retimed),
        .pfd_offset_i(pfd_offset),
        .value_o     (adcout_unfolded)
    );

    slice_comparator #(.n_ti(n_ti), .n_adc(n_adc)) comp_i (
        .clk_adc_i(clk_adc_i),
        .arst_n_i (arst_n_i),
        .value_i  (adcout_unfolded),
        .thresh_i (thresh),
        .bits_o   (rx_bits)
    );

    prbs_checker #(.n_ti(n_ti)) prbs_checker_i (
        .clk_adc_i  (clk_adc_i),
        .arst_n_i   (arst_n_i),
        .bits_i     (rx_bits),
        .enable_i   (prbs_en),
        .invert_i   (prbs_inv),
        .err_cnt_o  (err_cnt),
        .total_cnt_o(total_cnt)
    );

endmodule

/* logic/prbs_checker.sv */
`timescale 1ns/1ps

module prbs_checker #(
    parameter int n_ti = dcore_pkg::n_ti_default
) (
    input  logic             clk_adc_i,
    input  logic             arst_n_i,
    input  logic [n_ti-1:0]  bits_i,
    input  logic             enable_i,
    input  logic             invert_i,
    output logic [31:0]      err_cnt_o,
    output logic [31:0]      total_cnt_o
);

    import dcore_pkg::*;

    prbs_state_e                  state_q;
    logic [n_ti-1:0]              rx_bits;
    logic [prbs_order-1:0]        hist_q;
    logic [n_ti+prbs_order-1:0]   stream;
    logic [n_ti-1:0]              err_vec;
    logic [31:0]                  err_sum;

    // optional polarity flip of the whole word
    assign rx_bits = bits_i ^ {n_ti{invert_i}};

    // received history sits below the new word, oldest bit at index 0
    assign stream = {rx_bits, hist_q};

    // each bit should equal the xor of the bits 6 and 7 positions back
    always_comb begin
        err_sum = '0;
        for (int j = 0; j < n_ti; j++) begin
            err_vec[j] = stream[prbs_order + j] ^ stream[j + 1] ^ stream[j];
            err_sum    = err_sum + 32'(err_vec[j]);
        end
    end

    // self-synchronizing, so history follows the received stream
    always_ff @(posedge clk_adc_i) begin
        hist_q <= stream[n_ti +: prbs_order];
    end

    always_ff @(posedge clk_adc_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q     <= PRBS_IDLE;
            err_cnt_o   <= '0;
            total_cnt_o <= '0;
        end else begin
            case (state_q)
                PRBS_IDLE: begin
                    // new run starts from zero
                    if (enable_i) begin
                        state_q     <= PRBS_SEED;
                        err_cnt_o   <= '0;
                        total_cnt_o <= '0;
                    end
                end
                PRBS_SEED: begin
                    state_q <= enable_i ? PRBS_CHECK : PRBS_IDLE;
                end
                PRBS_CHECK: begin
                    if (!enable_i) begin
                        state_q <= PRBS_IDLE;
                    end else begin
                        err_cnt_o   <= err_cnt_o + err_sum;
                        total_cnt_o <= total_cnt_o + 32'(n_ti);
                    end
                end
                default: begin
                    state_q <= PRBS_IDLE;
                end
            endcase
        end
    end

endmodule

/* logic/slice_comparator.sv */
`timescale 1ns/1ps

module slice_comparator #(
    parameter int n_ti  = dcore_pkg::n_ti_default,
    parameter int n_adc = dcore_pkg::n_adc_default
) (
    input  logic                             clk_adc_i,
    input  logic                             arst_n_i,
    input  logic signed [n_ti-1:0][n_adc:0]  value_i,
    input  logic signed [n_adc:0]            thresh_i,
    output logic [n_ti-1:0]                  bits_o
);

    logic [n_ti-1:0] bits_d;

    // strictly above threshold decides a one
    always_comb begin
        for (int k = 0; k < n_ti; k++) begin
            bits_d[k] = $signed(value_i[k]) > thresh_i;
        end
    end

    always_ff @(posedge clk_adc_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            bits_o <= '0;
        end else begin
            bits_o <= bits_d;
        end
    end

endmodule

/* tests/digital_core_tb.sv */
`timescale 1ns/1ps

module digital_core_tb;

    import dcore_pkg::*;

    localparam int n_ti      = n_ti_default;
    localparam int n_adc     = n_adc_default;
    localparam int n_rows    = 6;
    localparam int bit_depth = 8192;

    logic                       clk_adc_i;
    logic                       arst_n_i;
    logic [4:0]                 paddr_i;
    logic                       psel_i;
    logic                       penable_i;
    logic                       pwrite_i;
    logic [31:0]                pwdata_i;
    logic [31:0]                prdata_o;
    logic                       pready_o;
    logic                       pslverr_o;
    logic [n_ti-1:0][n_adc-1:0] adcout_i;
    logic [n_ti-1:0]            adcout_sign_i;

    int seed           = 95;
    int cycle_cnt      = 0;
    int timeout_cycles = 100000;
    int fail_count     = 0;
    int tests_run      = 0;
    int tests_failed   = 0;

    // reference prbs7 bits and how the stimulus shapes them
    logic            prbs_bits [bit_depth];
    logic [n_ti-1:0] gen_mask  = '0;
    logic            gen_inv   = 1'b0;
    int              flip_base = 0;
    int              act_flip [3] = '{-1, -1, -1};

    // test table
    string       row_name [n_rows];
    logic [31:0] row_ctrl [n_rows];
    logic [31:0] row_offset [n_rows];
    logic [31:0] row_thresh [n_rows];
    int          row_words [n_rows];
    int          row_flip [n_rows][3];
    int          row_exp_err [n_rows];

    digital_core #(.n_ti(n_ti), .n_adc(n_adc)) DUT (
        .clk_adc_i    (clk_adc_i),
        .arst_n_i     (arst_n_i),
        .paddr_i      (paddr_i),
        .psel_i       (psel_i),
        .penable_i    (penable_i),
        .pwrite_i     (pwrite_i),
        .pwdata_i     (pwdata_i),
        .prdata_o     (prdata_o),
        .pready_o     (pready_o),
        .pslverr_o    (pslverr_o),
        .adcout_i     (adcout_i),
        .adcout_sign_i(adcout_sign_i)
    );

    initial begin
        clk_adc_i = 1'b0;
        forever #50 clk_adc_i = ~clk_adc_i;
    end

    // cycle counter doubles as the run limit
    initial begin
        forever begin
            @(posedge clk_adc_i);
            cycle_cnt = cycle_cnt + 1;
            if (cycle_cnt > timeout_cycles) begin
                $display("run timed out after %0d cycles without finishing the tests", cycle_cnt);
                $display("RESULT: FAIL");
                $finish;
            end
        end
    end

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            fail_count = fail_count + 1;
            $display("ERROR at %0t ns: %s got 0x%08h expected 0x%08h", $time, what, got, exp);
        end
    endtask

    // b[i] = b[i-6] ^ b[i-7] with the first bits taken from the seed
    task automatic make_prbs();
        for (int i = 0; i < bit_depth; i++) begin
            if (i < prbs_order) begin
                prbs_bits[i] = seed[i];
            end else begin
                prbs_bits[i] = prbs_bits[i - prbs_order + 1] ^ prbs_bits[i - prbs_order];
            end
        end
    endtask

    function automatic logic stim_bit(input int word, input int slice);
        int   rel;
        logic b;
        rel = (word - flip_base) * n_ti + slice;
        b   = prbs_bits[word * n_ti + slice] ^ gen_inv;
        for (int i = 0; i < 3; i++) begin
            if (act_flip[i] >= 0 && rel == act_flip[i]) begin
                b = ~b;
            end
        end
        return b;
    endfunction

    // adc model whose word index follows the cycle count
    initial begin
        adcout_i      = '0;
        adcout_sign_i = '0;
        forever begin
            @(negedge clk_adc_i);
            for (int k = 0; k < n_ti; k++) begin
                // early slices already carry the next word
                adcout_sign_i[k] = stim_bit(cycle_cnt + int'(gen_mask[k]), k);
                adcout_i[k]      = n_adc'(16 + $unsigned($random(seed)) % 48);
            end
        end
    end

    // one transfer started on a falling edge
    task automatic apb_xfer(input logic write, input logic [4:0] addr, input logic [31:0] wdata,
                            output logic [31:0] rdata, output logic err);
        paddr_i   = addr;
        pwrite_i  = write;
        pwdata_i  = wdata;
        psel_i    = 1'b1;
        penable_i = 1'b0;
        @(negedge clk_adc_i);
        penable_i = 1'b1;
        #20;
        rdata = prdata_o;
        err   = pslverr_o;
        check_value("pready", 32'(pready_o), 32'd1);
        @(negedge clk_adc_i);
        psel_i    = 1'b0;
        penable_i = 1'b0;
        pwrite_i  = 1'b0;
    endtask

    task automatic write_reg(input logic [4:0] addr, input logic [31:0] data,
                             input logic exp_err);
        logic [31:0] rdata;
        logic        err;
        apb_xfer(1'b1, addr, data, rdata, err);
        check_value($sformatf("pslverr on write of 0x%02h", addr), 32'(err), 32'(exp_err));
    endtask

    task automatic read_reg(input logic [4:0] addr, input logic [31:0] exp_data,
                            input logic exp_err);
        logic [31:0] rdata;
        logic        err;
        apb_xfer(1'b0, addr, '0, rdata, err);
        check_value($sformatf("pslverr on read of 0x%02h", addr), 32'(err), 32'(exp_err));
        if (!exp_err) begin
            check_value($sformatf("read of 0x%02h", addr), rdata, exp_data);
        end
    endtask

    task automatic finish_test(input string name, input int fails_before);
        tests_run = tests_run + 1;
        if (fail_count == fails_before) begin
            $display("test %s: ok", name);
        end else begin
            tests_failed = tests_failed + 1;
            $display("test %s: FAILED with %0d mismatches", name, fail_count - fails_before);
        end
    endtask

    task automatic set_row(input int r, input string name, input logic [31:0] ctrl,
                           input logic [31:0] offset, input logic [31:0] thresh, input int words,
                           input int f0, input int f1, input int f2, input int exp_err);
        row_name[r]    = name;
        row_ctrl[r]    = ctrl;
        row_offset[r]  = offset;
        row_thresh[r]  = thresh;
        row_words[r]   = words;
        row_flip[r][0] = f0;
        row_flip[r][1] = f1;
        row_flip[r][2] = f2;
        row_exp_err[r] = exp_err;
    endtask

    // 3 errors per isolated flip and none for a re-inverted stream
    // all ones fails every checked bit
    task automatic load_table();
        set_row(0, "clean_prbs", 32'h001, 32'h0, 32'h0, 40, -1, -1, -1, 0);
        // offset -64 lifts every value and threshold 64 splits them again
        set_row(1, "offset_thresh", 32'h001, 32'hFFFF_FFC0, 32'h40, 40, -1, -1, -1, 0);
        set_row(2, "bit_flips", 32'h001, 32'h0, 32'h0, 60, 20, 57, 101, 3 * 3);
        set_row(3, "inverted", 32'h003, 32'h0, 32'h0, 40, -1, -1, -1, 0);
        set_row(4, "retime_mask", 32'h501, 32'h0, 32'h0, 40, -1, -1, -1, 0);
        set_row(5, "offset_neg64", 32'h001, 32'hFFFF_FFC0, 32'h0, 40, -1, -1, -1,
                n_ti * (40 - 1));
    endtask

    task automatic run_row(input int r);
        int fails_before;
        int base;
        fails_before = fail_count;
        gen_mask <= row_ctrl[r][8 +: n_ti];
        gen_inv  <= row_ctrl[r][1];
        write_reg(REG_CTRL, row_ctrl[r] & 32'hFFFF_FFFE, 1'b0);
        write_reg(REG_OFFSET, row_offset[r], 1'b0);
        write_reg(REG_THRESH, row_thresh[r], 1'b0);
        repeat (10) @(negedge clk_adc_i);
        // seed word is driven now and checked words start with the next one
        base = cycle_cnt + 1;
        flip_base <= base;
        for (int i = 0; i < 3; i++) begin
            act_flip[i] <= row_flip[r][i];
        end
        write_reg(REG_CTRL, row_ctrl[r], 1'b0);
        read_reg(REG_CTRL, row_ctrl[r], 1'b0);
        while (cycle_cnt < base + row_words[r]) begin
            @(negedge clk_adc_i);
        end
        write_reg(REG_CTRL, row_ctrl[r] & 32'hFFFF_FFFE, 1'b0);
        repeat (10) @(negedge clk_adc_i);
        for (int i = 0; i < 3; i++) begin
            act_flip[i] <= -1;
        end
        read_reg(REG_ERR_CNT, 32'(row_exp_err[r]), 1'b0);
        read_reg(REG_TOTAL_CNT, 32'(n_ti * (row_words[r] - 1)), 1'b0);
        finish_test(row_name[r], fails_before);
    endtask

    initial begin
        int sum_words;
        int fails_before;
        arst_n_i  = 1'b0;
        paddr_i   = '0;
        psel_i    = 1'b0;
        penable_i = 1'b0;
        pwrite_i  = 1'b0;
        pwdata_i  = '0;
        make_prbs();
        load_table();
        sum_words = 0;
        for (int r = 0; r < n_rows; r++) begin
            sum_words = sum_words + row_words[r];
        end
        timeout_cycles = 2 * sum_words + 500;
        repeat (10) @(negedge clk_adc_i);
        arst_n_i = 1'b1;
        @(negedge clk_adc_i);

        fails_before = fail_count;
        read_reg(REG_CTRL, 32'h0, 1'b0);
        read_reg(REG_OFFSET, 32'h0, 1'b0);
        read_reg(REG_THRESH, 32'h0, 1'b0);
        read_reg(REG_ERR_CNT, 32'h0, 1'b0);
        read_reg(REG_TOTAL_CNT, 32'h0, 1'b0);
        finish_test("reset_values", fails_before);

        // fields keep only their own bits
        fails_before = fail_count;
        write_reg(REG_CTRL, 32'hFFFF_FFFE, 1'b0);
        write_reg(REG_OFFSET, 32'h1234_5685, 1'b0);
        write_reg(REG_THRESH, 32'hABCD_EF7A, 1'b0);
        read_reg(REG_CTRL, 32'h0000_0F02, 1'b0);
        read_reg(REG_OFFSET, 32'h0000_0085, 1'b0);
        read_reg(REG_THRESH, 32'h0000_007A, 1'b0);
        finish_test("readback", fails_before);

        fails_before = fail_count;
        read_reg(5'h14, 32'h0, 1'b1);
        write_reg(5'h02, 32'hFFFF_FFFF, 1'b1);
        write_reg(REG_ERR_CNT, 32'h5A5A_5A5A, 1'b1);
        read_reg(REG_ERR_CNT, 32'h0, 1'b0);
        read_reg(REG_CTRL, 32'h0000_0F02, 1'b0);
        read_reg(REG_OFFSET, 32'h0000_0085, 1'b0);
        read_reg(REG_THRESH, 32'h0000_007A, 1'b0);
        write_reg(REG_CTRL, 32'h0, 1'b0);
        finish_test("slave_error", fails_before);

        for (int r = 0; r < n_rows; r++) begin
            run_row(r);
        end

        $display("tests run %0d, tests failed %0d, mismatches %0d",
                 tests_run, tests_failed, fail_count);
        if (fail_count == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule
